// ==== core_defs.svh ====
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// Datapath width
`define CORE_XLEN 32

// Architectural register number width
`define CORE_REG_ADDR_W 5

// Immediate field carried by a decoded instruction
`define CORE_IMM_W 12

// Instructions fetched, dispatched and committed per cycle
`define CORE_ISSUE_W 2

// Instruction buffer entries, power of two
`define CORE_IB_DEPTH 8

`endif

// ==== core_pkg.sv ====
`include "core_defs.svh"

package core_pkg;

    typedef enum logic [2:0] {
        ADD = 3'd0,
        SUB = 3'd1,
        AND = 3'd2,
        OR  = 3'd3,
        XOR = 3'd4,
        SLL = 3'd5,
        SRL = 3'd6,
        SLT = 3'd7  // Signed compare
    } alu_op_e;

    // Decoded instruction as delivered by the front end
    typedef struct packed {
        logic [`CORE_XLEN-1:0]       pc;
        alu_op_e                     op;
        logic [`CORE_REG_ADDR_W-1:0] rd;
        logic [`CORE_REG_ADDR_W-1:0] rs1;
        logic [`CORE_REG_ADDR_W-1:0] rs2;
        logic                        use_imm;  // b from imm instead of rs2
        logic [`CORE_IMM_W-1:0]      imm;
        logic [24:0]                 pad;
    } instr_t;

    // Finished instruction leaving a lane
    typedef struct packed {
        logic                        valid;
        logic [`CORE_XLEN-1:0]       pc;
        logic [`CORE_REG_ADDR_W-1:0] rd;
        logic [`CORE_XLEN-1:0]       wdata;
    } lane_result_t;

endpackage

// ==== instr_buffer.sv ====
`timescale 1ns/1ps
`include "core_defs.svh"

module instr_buffer #(
    parameter int DEPTH = `CORE_IB_DEPTH
) (
    input  logic                     clk,
    input  logic                     reset_i,

    input  logic [`CORE_ISSUE_W-1:0] in_valid_i,
    input  core_pkg::instr_t         in_instr0_i,
    input  core_pkg::instr_t         in_instr1_i,
    output logic                     in_ready_o,

    output logic [`CORE_ISSUE_W-1:0] head_valid_o,
    output core_pkg::instr_t         head_instr0_o,
    output core_pkg::instr_t         head_instr1_o,
    input  logic [`CORE_ISSUE_W-1:0] accept_i
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    core_pkg::instr_t mem [DEPTH];

    logic [PTR_W-1:0] rptr_q;
    logic [PTR_W-1:0] wptr_q;
    logic [PTR_W-1:0] rptr_p1;
    logic [PTR_W-1:0] wptr_p1;
    logic [CNT_W-1:0] count_q;
    logic [CNT_W-1:0] count_nxt;
    logic [CNT_W-1:0] n_in;
    logic [CNT_W-1:0] n_out;
    logic             ready_q;
    logic             wr0;
    logic             wr1;

    assign rptr_p1 = rptr_q + 1'b1;
    assign wptr_p1 = wptr_q + 1'b1;

    // Slot 1 is only ever valid together with slot 0
    assign wr0 = ready_q && in_valid_i[0];
    assign wr1 = ready_q && in_valid_i[1];

    assign n_in      = CNT_W'(wr0) + CNT_W'(wr1);
    assign n_out     = CNT_W'(accept_i[0]) + CNT_W'(accept_i[1]);
    assign count_nxt = count_q + n_in - n_out;

    always_ff @(posedge clk) begin
        if (wr0) begin
            mem[wptr_q] <= in_instr0_i;
        end
        if (wr1) begin
            mem[wptr_p1] <= in_instr1_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            rptr_q  <= '0;
            wptr_q  <= '0;
            count_q <= '0;
            ready_q <= 1'b0;
        end else begin
            wptr_q  <= wptr_q + PTR_W'(n_in);
            rptr_q  <= rptr_q + PTR_W'(n_out);
            count_q <= count_nxt;
            ready_q <= count_nxt <= CNT_W'(DEPTH - 2);  // Room for a full pair
        end
    end

    assign in_ready_o = ready_q;

    // Oldest entry in slot 0
    assign head_valid_o[0] = count_q != '0;
    assign head_valid_o[1] = count_q >= CNT_W'(2);
    assign head_instr0_o   = mem[rptr_q];
    assign head_instr1_o   = mem[rptr_p1];

endmodule

// ==== regfile.sv ====
`timescale 1ns/1ps
`include "core_defs.svh"

module regfile (
    input  logic                        clk,
    input  logic                        reset_i,

    input  logic [`CORE_REG_ADDR_W-1:0] raddr0_i,
    input  logic [`CORE_REG_ADDR_W-1:0] raddr1_i,
    input  logic [`CORE_REG_ADDR_W-1:0] raddr2_i,
    input  logic [`CORE_REG_ADDR_W-1:0] raddr3_i,
    output logic [`CORE_XLEN-1:0]       rdata0_o,
    output logic [`CORE_XLEN-1:0]       rdata1_o,
    output logic [`CORE_XLEN-1:0]       rdata2_o,
    output logic [`CORE_XLEN-1:0]       rdata3_o,

    input  logic                        we0_i,
    input  logic [`CORE_REG_ADDR_W-1:0] waddr0_i,
    input  logic [`CORE_XLEN-1:0]       wdata0_i,
    input  logic                        we1_i,
    input  logic [`CORE_REG_ADDR_W-1:0] waddr1_i,
    input  logic [`CORE_XLEN-1:0]       wdata1_i
);

    localparam int NREGS = 1 << `CORE_REG_ADDR_W;

    logic [`CORE_XLEN-1:0] regs [NREGS];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < NREGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (we0_i && waddr0_i != '0) begin
                regs[waddr0_i] <= wdata0_i;
            end
            if (we1_i && waddr1_i != '0) begin
                regs[waddr1_i] <= wdata1_i;  // Younger lane wins on a tie
            end
        end
    end

    // x0 hardwired to zero
    assign rdata0_o = (raddr0_i == '0) ? '0 : regs[raddr0_i];
    assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];
    assign rdata3_o = (raddr3_i == '0) ? '0 : regs[raddr3_i];

endmodule

// ==== dispatch.sv ====
`timescale 1ns/1ps
`include "core_defs.svh"

module dispatch (
    input  logic                        clk,
    input  logic                        reset_i,

    input  logic [`CORE_ISSUE_W-1:0]    head_valid_i,
    input  core_pkg::instr_t            head_instr0_i,
    input  core_pkg::instr_t            head_instr1_i,
    output logic [`CORE_ISSUE_W-1:0]    accept_o,

    output logic [`CORE_REG_ADDR_W-1:0] rf_raddr0_o,
    output logic [`CORE_REG_ADDR_W-1:0] rf_raddr1_o,
    output logic [`CORE_REG_ADDR_W-1:0] rf_raddr2_o,
    output logic [`CORE_REG_ADDR_W-1:0] rf_raddr3_o,
    input  logic [`CORE_XLEN-1:0]       rf_rdata0_i,
    input  logic [`CORE_XLEN-1:0]       rf_rdata1_i,
    input  logic [`CORE_XLEN-1:0]       rf_rdata2_i,
    input  logic [`CORE_XLEN-1:0]       rf_rdata3_i,

    input  core_pkg::lane_result_t      ex0_i,
    input  core_pkg::lane_result_t      ex1_i,
    input  core_pkg::lane_result_t      wb0_i,
    input  core_pkg::lane_result_t      wb1_i,

    output logic                        lane0_valid_o,
    output logic [`CORE_XLEN-1:0]       lane0_pc_o,
    output core_pkg::alu_op_e           lane0_op_o,
    output logic [`CORE_REG_ADDR_W-1:0] lane0_rd_o,
    output logic [`CORE_XLEN-1:0]       lane0_a_o,
    output logic [`CORE_XLEN-1:0]       lane0_b_o,
    output logic                        lane1_valid_o,
    output logic [`CORE_XLEN-1:0]       lane1_pc_o,
    output core_pkg::alu_op_e           lane1_op_o,
    output logic [`CORE_REG_ADDR_W-1:0] lane1_rd_o,
    output logic [`CORE_XLEN-1:0]       lane1_a_o,
    output logic [`CORE_XLEN-1:0]       lane1_b_o
);

    // Oldest producer first so the newest one overrides
    function automatic logic [`CORE_XLEN-1:0] pick_src(
        input logic [`CORE_REG_ADDR_W-1:0] src,
        input logic [`CORE_XLEN-1:0]       rf_data,
        input core_pkg::lane_result_t      wb0,
        input core_pkg::lane_result_t      wb1,
        input core_pkg::lane_result_t      ex0,
        input core_pkg::lane_result_t      ex1
    );
        logic [`CORE_XLEN-1:0] val;
        val = rf_data;
        if (src != '0) begin
            if (wb0.valid && wb0.rd == src) val = wb0.wdata;
            if (wb1.valid && wb1.rd == src) val = wb1.wdata;
            if (ex0.valid && ex0.rd == src) val = ex0.wdata;
            if (ex1.valid && ex1.rd == src) val = ex1.wdata;
        end
        return val;
    endfunction

    core_pkg::instr_t        ins    [`CORE_ISSUE_W];
    logic [`CORE_XLEN-1:0]   rs1_val[`CORE_ISSUE_W];
    logic [`CORE_XLEN-1:0]   rs2_val[`CORE_ISSUE_W];
    logic [`CORE_XLEN-1:0]   opb    [`CORE_ISSUE_W];
    logic [`CORE_ISSUE_W-1:0] issue;
    logic                    pair_dep;

    logic [`CORE_ISSUE_W-1:0]    vld_q;
    logic [`CORE_XLEN-1:0]       pc_q[`CORE_ISSUE_W];
    core_pkg::alu_op_e           op_q[`CORE_ISSUE_W];
    logic [`CORE_REG_ADDR_W-1:0] rd_q[`CORE_ISSUE_W];
    logic [`CORE_XLEN-1:0]       a_q [`CORE_ISSUE_W];
    logic [`CORE_XLEN-1:0]       b_q [`CORE_ISSUE_W];

    assign ins[0] = head_instr0_i;
    assign ins[1] = head_instr1_i;

    assign rf_raddr0_o = ins[0].rs1;
    assign rf_raddr1_o = ins[0].rs2;
    assign rf_raddr2_o = ins[1].rs1;
    assign rf_raddr3_o = ins[1].rs2;

    assign rs1_val[0] = pick_src(ins[0].rs1, rf_rdata0_i, wb0_i, wb1_i, ex0_i, ex1_i);
    assign rs2_val[0] = pick_src(ins[0].rs2, rf_rdata1_i, wb0_i, wb1_i, ex0_i, ex1_i);
    assign rs1_val[1] = pick_src(ins[1].rs1, rf_rdata2_i, wb0_i, wb1_i, ex0_i, ex1_i);
    assign rs2_val[1] = pick_src(ins[1].rs2, rf_rdata3_i, wb0_i, wb1_i, ex0_i, ex1_i);

    for (genvar i = 0; i < `CORE_ISSUE_W; i++) begin : g_opb
        assign opb[i] = ins[i].use_imm
            ? {{(`CORE_XLEN - `CORE_IMM_W){ins[i].imm[`CORE_IMM_W-1]}}, ins[i].imm}
            : rs2_val[i];
    end

    // Second slot waits a cycle if it needs the first one's result
    assign pair_dep = ins[0].rd != '0 &&
                      (ins[1].rs1 == ins[0].rd || (!ins[1].use_imm && ins[1].rs2 == ins[0].rd));

    assign issue[0] = head_valid_i[0];
    assign issue[1] = head_valid_i[0] && head_valid_i[1] && !pair_dep;
    assign accept_o = issue;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            vld_q <= '0;
        end else begin
            vld_q <= issue;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < `CORE_ISSUE_W; i++) begin
            pc_q[i] <= ins[i].pc;
            op_q[i] <= ins[i].op;
            rd_q[i] <= ins[i].rd;
            a_q[i]  <= rs1_val[i];
            b_q[i]  <= opb[i];
        end
    end

    assign lane0_valid_o = vld_q[0];
    assign lane0_pc_o    = pc_q[0];
    assign lane0_op_o    = op_q[0];
    assign lane0_rd_o    = rd_q[0];
    assign lane0_a_o     = a_q[0];
    assign lane0_b_o     = b_q[0];
    assign lane1_valid_o = vld_q[1];
    assign lane1_pc_o    = pc_q[1];
    assign lane1_op_o    = op_q[1];
    assign lane1_rd_o    = rd_q[1];
    assign lane1_a_o     = a_q[1];
    assign lane1_b_o     = b_q[1];

endmodule

// ==== alu_lane.sv ====
`timescale 1ns/1ps
`include "core_defs.svh"

module alu_lane (
    input  logic                        clk,
    input  logic                        reset_i,

    input  logic                        valid_i,
    input  logic [`CORE_XLEN-1:0]       pc_i,
    input  core_pkg::alu_op_e           op_i,
    input  logic [`CORE_REG_ADDR_W-1:0] rd_i,
    input  logic [`CORE_XLEN-1:0]       a_i,
    input  logic [`CORE_XLEN-1:0]       b_i,

    output core_pkg::lane_result_t      ex_result_o,
    output core_pkg::lane_result_t      wb_result_o
);

    localparam int SHAMT_W = $clog2(`CORE_XLEN);

    logic [`CORE_XLEN-1:0]       result;
    logic                        wb_valid_q;
    logic [`CORE_XLEN-1:0]       wb_pc_q;
    logic [`CORE_REG_ADDR_W-1:0] wb_rd_q;
    logic [`CORE_XLEN-1:0]       wb_wdata_q;

    always_comb begin
        case (op_i)
            core_pkg::ADD: result = a_i + b_i;
            core_pkg::SUB: result = a_i - b_i;
            core_pkg::AND: result = a_i & b_i;
            core_pkg::OR:  result = a_i | b_i;
            core_pkg::XOR: result = a_i ^ b_i;
            core_pkg::SLL: result = a_i << b_i[SHAMT_W-1:0];
            core_pkg::SRL: result = a_i >> b_i[SHAMT_W-1:0];
            core_pkg::SLT: result = {{(`CORE_XLEN-1){1'b0}}, $signed(a_i) < $signed(b_i)};
            default:       result = '0;
        endcase
    end

    // Forwarding tap in the execute cycle
    assign ex_result_o.valid = valid_i;
    assign ex_result_o.pc    = pc_i;
    assign ex_result_o.rd    = rd_i;
    assign ex_result_o.wdata = result;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            wb_valid_q <= 1'b0;
        end else begin
            wb_valid_q <= valid_i;
        end
    end

    always_ff @(posedge clk) begin
        wb_pc_q    <= pc_i;
        wb_rd_q    <= rd_i;
        wb_wdata_q <= result;
    end

    assign wb_result_o.valid = wb_valid_q;
    assign wb_result_o.pc    = wb_pc_q;
    assign wb_result_o.rd    = wb_rd_q;
    assign wb_result_o.wdata = wb_wdata_q;

endmodule

// ==== core_top.sv ====
`timescale 1ns/1ps
`include "core_defs.svh"

module core_top (
    input  logic                        clk,
    input  logic                        reset_i,

    input  logic [`CORE_ISSUE_W-1:0]    fetch_valid_i,
    input  core_pkg::instr_t            fetch_instr0_i,
    input  core_pkg::instr_t            fetch_instr1_i,
    output logic                        fetch_ready_o,

    output logic                        commit0_valid_o,
    output logic [`CORE_XLEN-1:0]       commit0_pc_o,
    output logic                        commit0_wen_o,
    output logic [`CORE_REG_ADDR_W-1:0] commit0_wnum_o,
    output logic [`CORE_XLEN-1:0]       commit0_wdata_o,
    output logic                        commit1_valid_o,
    output logic [`CORE_XLEN-1:0]       commit1_pc_o,
    output logic                        commit1_wen_o,
    output logic [`CORE_REG_ADDR_W-1:0] commit1_wnum_o,
    output logic [`CORE_XLEN-1:0]       commit1_wdata_o
);

    logic [`CORE_ISSUE_W-1:0]    head_valid;
    core_pkg::instr_t            head_instr0;
    core_pkg::instr_t            head_instr1;
    logic [`CORE_ISSUE_W-1:0]    accept;

    logic [`CORE_REG_ADDR_W-1:0] rf_raddr0, rf_raddr1, rf_raddr2, rf_raddr3;
    logic [`CORE_XLEN-1:0]       rf_rdata0, rf_rdata1, rf_rdata2, rf_rdata3;

    logic                        l0_valid, l1_valid;
    logic [`CORE_XLEN-1:0]       l0_pc, l1_pc;
    core_pkg::alu_op_e           l0_op, l1_op;
    logic [`CORE_REG_ADDR_W-1:0] l0_rd, l1_rd;
    logic [`CORE_XLEN-1:0]       l0_a, l0_b, l1_a, l1_b;

    core_pkg::lane_result_t      ex0, ex1, wb0, wb1;
    logic                        wen0, wen1;

    instr_buffer #(
        .DEPTH(`CORE_IB_DEPTH)
    ) u_instr_buffer (
        .clk(clk), .reset_i(reset_i),
        .in_valid_i(fetch_valid_i), .in_instr0_i(fetch_instr0_i),
        .in_instr1_i(fetch_instr1_i), .in_ready_o(fetch_ready_o),
        .head_valid_o(head_valid), .head_instr0_o(head_instr0),
        .head_instr1_o(head_instr1), .accept_i(accept)
    );

    dispatch u_dispatch (
        .clk(clk), .reset_i(reset_i),
        .head_valid_i(head_valid), .head_instr0_i(head_instr0),
        .head_instr1_i(head_instr1), .accept_o(accept),
        .rf_raddr0_o(rf_raddr0), .rf_raddr1_o(rf_raddr1),
        .rf_raddr2_o(rf_raddr2), .rf_raddr3_o(rf_raddr3),
        .rf_rdata0_i(rf_rdata0), .rf_rdata1_i(rf_rdata1),
        .rf_rdata2_i(rf_rdata2), .rf_rdata3_i(rf_rdata3),
        .ex0_i(ex0), .ex1_i(ex1), .wb0_i(wb0), .wb1_i(wb1),
        .lane0_valid_o(l0_valid), .lane0_pc_o(l0_pc), .lane0_op_o(l0_op),
        .lane0_rd_o(l0_rd), .lane0_a_o(l0_a), .lane0_b_o(l0_b),
        .lane1_valid_o(l1_valid), .lane1_pc_o(l1_pc), .lane1_op_o(l1_op),
        .lane1_rd_o(l1_rd), .lane1_a_o(l1_a), .lane1_b_o(l1_b)
    );

    alu_lane u_lane0 (
        .clk(clk), .reset_i(reset_i),
        .valid_i(l0_valid), .pc_i(l0_pc), .op_i(l0_op), .rd_i(l0_rd),
        .a_i(l0_a), .b_i(l0_b), .ex_result_o(ex0), .wb_result_o(wb0)
    );

    alu_lane u_lane1 (
        .clk(clk), .reset_i(reset_i),
        .valid_i(l1_valid), .pc_i(l1_pc), .op_i(l1_op), .rd_i(l1_rd),
        .a_i(l1_a), .b_i(l1_b), .ex_result_o(ex1), .wb_result_o(wb1)
    );

    // Writeback, x0 writes suppressed
    assign wen0 = wb0.valid && wb0.rd != '0;
    assign wen1 = wb1.valid && wb1.rd != '0;

    regfile u_regfile (
        .clk(clk), .reset_i(reset_i),
        .raddr0_i(rf_raddr0), .raddr1_i(rf_raddr1),
        .raddr2_i(rf_raddr2), .raddr3_i(rf_raddr3),
        .rdata0_o(rf_rdata0), .rdata1_o(rf_rdata1),
        .rdata2_o(rf_rdata2), .rdata3_o(rf_rdata3),
        .we0_i(wen0), .waddr0_i(wb0.rd), .wdata0_i(wb0.wdata),
        .we1_i(wen1), .waddr1_i(wb1.rd), .wdata1_i(wb1.wdata)
    );

    assign commit0_valid_o = wb0.valid;  // Port 0 is the older one
    assign commit0_pc_o    = wb0.pc;
    assign commit0_wen_o   = wen0;
    assign commit0_wnum_o  = wb0.rd;
    assign commit0_wdata_o = wb0.wdata;
    assign commit1_valid_o = wb1.valid;
    assign commit1_pc_o    = wb1.pc;
    assign commit1_wen_o   = wen1;
    assign commit1_wnum_o  = wb1.rd;
    assign commit1_wdata_o = wb1.wdata;

endmodule

// ==== core_checker.sv ====
`timescale 1ns/1ps
`include "core_defs.svh"

module core_checker (
    input logic                        clk,
    input logic                        reset_i,
    input logic                        fetch_ready_i,
    input logic                        commit0_valid_i,
    input logic                        commit0_wen_i,
    input logic [`CORE_REG_ADDR_W-1:0] commit0_wnum_i,
    input logic                        commit1_valid_i,
    input logic                        commit1_wen_i,
    input logic [`CORE_REG_ADDR_W-1:0] commit1_wnum_i
);

    int assert_fails = 0;

    // Port 1 never retires alone
    commit_order: assert property (@(posedge clk) disable iff (reset_i)
        commit1_valid_i |-> commit0_valid_i)
        else begin
            assert_fails++;
            $error("commit1 valid without commit0 valid");
        end

    wen0_nonzero: assert property (@(posedge clk) disable iff (reset_i)
        commit0_wen_i |-> commit0_wnum_i != '0)
        else begin
            assert_fails++;
            $error("commit0 write enable with wnum zero");
        end

    wen1_nonzero: assert property (@(posedge clk) disable iff (reset_i)
        commit1_wen_i |-> commit1_wnum_i != '0)
        else begin
            assert_fails++;
            $error("commit1 write enable with wnum zero");
        end

    ready_in_reset: assert property (@(posedge clk) reset_i |=> !fetch_ready_i)
        else begin
            assert_fails++;
            $error("fetch ready high during reset");
        end

    // First cycle out of reset
    quiet_after_reset: assert property (@(posedge clk)
        $fell(reset_i) |-> !commit0_valid_i && !commit1_valid_i)
        else begin
            assert_fails++;
            $error("commit valid in the first cycle after reset");
        end

endmodule

// ==== core_clock_gen.sv ====
`timescale 1ns/1ps

module core_clock_gen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic reset_o
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        reset_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 reset_o = 1'b0;  // Released just after the edge
    end

endmodule

// ==== core_tb.sv ====
`timescale 1ns/1ps
`include "core_defs.svh"

module core_tb;

    localparam int N_DIR        = 39;
    localparam int N_RAND_PAIRS = 64;
    localparam int MAX_CYCLES   = 4 * (N_DIR + 2 * N_RAND_PAIRS) + 100;
    localparam logic [31:0] SEED = 32'h356d0c38;

    typedef struct packed {
        logic                        solo;  // Sent alone, valid 01
        core_pkg::alu_op_e           op;
        logic [`CORE_REG_ADDR_W-1:0] rd;
        logic [`CORE_REG_ADDR_W-1:0] rs1;
        logic [`CORE_REG_ADDR_W-1:0] rs2;
        logic                        use_imm;
        logic [`CORE_IMM_W-1:0]      imm;
        logic [`CORE_XLEN-1:0]       exp;
    } dir_row_t;

    typedef struct packed {
        logic [`CORE_XLEN-1:0]       pc;
        logic [`CORE_REG_ADDR_W-1:0] rd;
        logic [`CORE_XLEN-1:0]       wdata;
    } commit_t;

    logic clk;
    logic reset;
    logic [`CORE_ISSUE_W-1:0] fetch_valid;
    core_pkg::instr_t fetch_instr0;
    core_pkg::instr_t fetch_instr1;
    logic fetch_ready;
    logic commit0_valid, commit0_wen, commit1_valid, commit1_wen;
    logic [`CORE_XLEN-1:0] commit0_pc, commit0_wdata, commit1_pc, commit1_wdata;
    logic [`CORE_REG_ADDR_W-1:0] commit0_wnum, commit1_wnum;

    dir_row_t tab [N_DIR];
    commit_t exp_q [$];
    logic [`CORE_XLEN-1:0] golden [32];  // Register state in program order
    logic [`CORE_XLEN-1:0] next_pc;
    int errors = 0;
    int checks = 0;
    int cycles = 0;
    int stalls = 0;

    core_clock_gen #(.PERIOD_NS(100), .RESET_CYCLES(8)) clock_gen_inst (
        .clk(clk), .reset_o(reset)
    );

    core_top core_top_inst (
        .clk(clk), .reset_i(reset),
        .fetch_valid_i(fetch_valid), .fetch_instr0_i(fetch_instr0),
        .fetch_instr1_i(fetch_instr1), .fetch_ready_o(fetch_ready),
        .commit0_valid_o(commit0_valid), .commit0_pc_o(commit0_pc), .commit0_wen_o(commit0_wen),
        .commit0_wnum_o(commit0_wnum), .commit0_wdata_o(commit0_wdata),
        .commit1_valid_o(commit1_valid), .commit1_pc_o(commit1_pc), .commit1_wen_o(commit1_wen),
        .commit1_wnum_o(commit1_wnum), .commit1_wdata_o(commit1_wdata)
    );

    bind core_top core_checker core_checker_inst (
        .clk(clk), .reset_i(reset_i), .fetch_ready_i(fetch_ready_o),
        .commit0_valid_i(commit0_valid_o), .commit0_wen_i(commit0_wen_o),
        .commit0_wnum_i(commit0_wnum_o), .commit1_valid_i(commit1_valid_o),
        .commit1_wen_i(commit1_wen_o), .commit1_wnum_i(commit1_wnum_o)
    );

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("** Error at time %0t: %s is 0x%08h, expected 0x%08h",
                     $time, name, actual, expected);
        end
    endtask

    function automatic logic [31:0] ref_alu(input core_pkg::alu_op_e op,
                                            input logic [31:0] a, input logic [31:0] b);
        case (op)
            core_pkg::ADD: return a + b;
            core_pkg::SUB: return a - b;
            core_pkg::AND: return a & b;
            core_pkg::OR:  return a | b;
            core_pkg::XOR: return a ^ b;
            core_pkg::SLL: return a << b[4:0];
            core_pkg::SRL: return a >> b[4:0];
            default:       return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        endcase
    endfunction

    // Expected result from golden state and retire it into golden
    function automatic logic [31:0] predict(input core_pkg::instr_t ins);
        logic [31:0] b;
        logic [31:0] r;
        b = ins.use_imm ? {{20{ins.imm[11]}}, ins.imm} : golden[ins.rs2];
        r = ref_alu(ins.op, golden[ins.rs1], b);
        if (ins.rd != 0) golden[ins.rd] = r;
        return r;
    endfunction

    function automatic core_pkg::instr_t make_instr(input core_pkg::alu_op_e op,
            input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2,
            input logic use_imm, input logic [11:0] imm);
        core_pkg::instr_t ins;
        ins = '0;
        ins.pc = next_pc;
        ins.op = op;
        ins.rd = rd;
        ins.rs1 = rs1;
        ins.rs2 = rs2;
        ins.use_imm = use_imm;
        ins.imm = imm;
        next_pc = next_pc + 32'd4;
        return ins;
    endfunction

    function automatic core_pkg::instr_t row_instr(input dir_row_t r);
        return make_instr(r.op, r.rd, r.rs1, r.rs2, r.use_imm, r.imm);
    endfunction

    function automatic core_pkg::instr_t random_instr();
        core_pkg::alu_op_e op;
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic use_imm;
        logic [11:0] imm;
        op = core_pkg::alu_op_e'($urandom_range(0, 7));
        rd = 5'($urandom_range(0, 4));  // Few registers for many hazards
        rs1 = 5'($urandom_range(0, 4));
        rs2 = 5'($urandom_range(0, 4));
        use_imm = 1'($urandom_range(0, 1));
        imm = 12'($urandom);
        return make_instr(op, rd, rs1, rs2, use_imm, imm);
    endfunction

    function automatic dir_row_t make_row(input logic solo, input core_pkg::alu_op_e op,
            input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2,
            input logic use_imm, input logic [11:0] imm, input logic [31:0] exp);
        return '{solo, op, rd, rs1, rs2, use_imm, imm, exp};
    endfunction

    task automatic load_table();
        tab[0]  = make_row(0, core_pkg::ADD,  1,  0,  0, 1, 12'h064, 32'h0000_0064);
        tab[1]  = make_row(0, core_pkg::ADD,  2,  0,  0, 1, 12'hFFD, 32'hFFFF_FFFD);
        tab[2]  = make_row(0, core_pkg::ADD,  3,  0,  0, 1, 12'h7FF, 32'h0000_07FF);
        tab[3]  = make_row(0, core_pkg::ADD,  4,  0,  0, 1, 12'h005, 32'h0000_0005);
        tab[4]  = make_row(0, core_pkg::ADD,  5,  1,  2, 0, 12'h000, 32'h0000_0061);
        tab[5]  = make_row(0, core_pkg::SUB,  6,  1,  2, 0, 12'h000, 32'h0000_0067);
        tab[6]  = make_row(0, core_pkg::AND,  7,  3,  4, 0, 12'h000, 32'h0000_0005);
        tab[7]  = make_row(0, core_pkg::OR,   8,  3,  2, 0, 12'h000, 32'hFFFF_FFFF);
        tab[8]  = make_row(0, core_pkg::XOR,  9,  3,  1, 0, 12'h000, 32'h0000_079B);
        tab[9]  = make_row(0, core_pkg::SLL, 10,  1,  4, 0, 12'h000, 32'h0000_0C80);
        tab[10] = make_row(0, core_pkg::SRL, 11,  2,  4, 0, 12'h000, 32'h07FF_FFFF);
        tab[11] = make_row(0, core_pkg::SLT, 12,  2,  1, 0, 12'h000, 32'h0000_0001);
        tab[12] = make_row(0, core_pkg::SLT, 13,  1,  2, 0, 12'h000, 32'h0000_0000);
        tab[13] = make_row(0, core_pkg::SLT, 14,  2,  0, 1, 12'hFFF, 32'h0000_0001);
        tab[14] = make_row(0, core_pkg::AND, 15,  2,  0, 1, 12'h0F0, 32'h0000_00F0);
        tab[15] = make_row(0, core_pkg::OR,  16,  1,  0, 1, 12'h800, 32'hFFFF_F864);
        tab[16] = make_row(0, core_pkg::XOR, 17,  3,  0, 1, 12'hFFF, 32'hFFFF_F800);
        tab[17] = make_row(0, core_pkg::SLL, 18,  4,  0, 1, 12'h01C, 32'h5000_0000);
        tab[18] = make_row(0, core_pkg::SRL, 19,  8,  0, 1, 12'h024, 32'h0FFF_FFFF);
        tab[19] = make_row(0, core_pkg::SUB, 20,  4,  0, 1, 12'h00A, 32'hFFFF_FFFB);
        // Dependent chain across back-to-back pairs
        tab[20] = make_row(0, core_pkg::ADD, 21,  0,  0, 1, 12'h001, 32'h0000_0001);
        tab[21] = make_row(0, core_pkg::ADD, 22,  0,  0, 1, 12'h002, 32'h0000_0002);
        tab[22] = make_row(0, core_pkg::ADD, 21, 21, 22, 0, 12'h000, 32'h0000_0003);
        tab[23] = make_row(0, core_pkg::ADD, 23, 22,  0, 1, 12'h00A, 32'h0000_000C);
        tab[24] = make_row(0, core_pkg::SLL, 24, 21, 22, 0, 12'h000, 32'h0000_000C);
        tab[25] = make_row(0, core_pkg::SUB, 25, 23, 22, 0, 12'h000, 32'h0000_000A);
        tab[26] = make_row(0, core_pkg::ADD, 26, 24, 25, 0, 12'h000, 32'h0000_0016);
        tab[27] = make_row(0, core_pkg::XOR, 27, 24, 21, 0, 12'h000, 32'h0000_000F);
        tab[28] = make_row(0, core_pkg::ADD, 28,  0,  0, 1, 12'h123, 32'h0000_0123);
        tab[29] = make_row(0, core_pkg::ADD, 29, 28, 28, 0, 12'h000, 32'h0000_0246);  // Split
        tab[30] = make_row(0, core_pkg::ADD, 30,  0,  0, 1, 12'h007, 32'h0000_0007);
        tab[31] = make_row(0, core_pkg::ADD, 30,  0,  0, 1, 12'h009, 32'h0000_0009);
        tab[32] = make_row(0, core_pkg::ADD, 31, 30,  0, 0, 12'h000, 32'h0000_0009);
        tab[33] = make_row(0, core_pkg::SUB,  1, 30, 28, 0, 12'h000, 32'hFFFF_FEE6);
        // x0 targets retire without a write
        tab[34] = make_row(0, core_pkg::ADD,  0,  0,  0, 1, 12'h037, 32'h0000_0037);
        tab[35] = make_row(0, core_pkg::ADD,  5,  0,  0, 0, 12'h000, 32'h0000_0000);
        tab[36] = make_row(0, core_pkg::ADD,  0,  1,  0, 1, 12'h001, 32'hFFFF_FEE7);
        tab[37] = make_row(0, core_pkg::OR,   6,  0,  3, 0, 12'h000, 32'h0000_07FF);
        tab[38] = make_row(1, core_pkg::SLT,  7,  1,  0, 0, 12'h000, 32'h0000_0001);
    endtask

    // Called 1 ns after a rising edge and returns 1 ns after the edge that took the pair
    task automatic send_pair(input logic [1:0] valid, input core_pkg::instr_t i0,
                             input core_pkg::instr_t i1, input logic [31:0] e0,
                             input logic [31:0] e1);
        logic taken;
        fetch_valid = valid;
        fetch_instr0 = i0;
        fetch_instr1 = i1;
        taken = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = fetch_ready;
            if (!taken) stalls++;
            @(posedge clk);
            #1;
        end
        exp_q.push_back('{i0.pc, i0.rd, e0});
        if (valid[1]) exp_q.push_back('{i1.pc, i1.rd, e1});
        fetch_valid = '0;
    endtask

    task automatic check_commit(input int port, input logic [31:0] pc, input logic wen,
                                input logic [4:0] wnum, input logic [31:0] wdata);
        commit_t e;
        if (exp_q.size() == 0) begin
            errors++;
            $display("Commit on port %0d at time %0t with no instruction outstanding",
                     port, $time);
        end else begin
            e = exp_q.pop_front();
            check($sformatf("commit%0d_pc_o", port), pc, e.pc);
            check($sformatf("commit%0d_wnum_o", port), wnum, e.rd);
            check($sformatf("commit%0d_wen_o", port), wen, e.rd != 0);
            check($sformatf("commit%0d_wdata_o", port), wdata, e.wdata);
        end
    endtask

    // Port 0 first as it holds the older instruction
    always @(negedge clk) begin
        if (!reset) begin
            if (commit0_valid) check_commit(0, commit0_pc, commit0_wen, commit0_wnum, commit0_wdata);
            if (commit1_valid) check_commit(1, commit1_pc, commit1_wen, commit1_wnum, commit1_wdata);
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("The run timed out after %0d cycles with %0d commits still missing",
                     cycles, exp_q.size());
            $display("Checks: %0d, errors: %0d", checks, errors);
            $display("Finished with errors");
            $finish;
        end
    end

    initial begin
        logic [1:0] v;
        core_pkg::instr_t i0;
        core_pkg::instr_t i1;
        logic [31:0] e0;
        logic [31:0] e1;
        int k;
        int dir_stalls;
        fetch_valid = '0;
        fetch_instr0 = '0;
        fetch_instr1 = '0;
        next_pc = 32'h0000_1000;
        for (int r = 0; r < 32; r++) golden[r] = '0;
        void'($urandom(SEED));
        load_table();

        @(negedge reset);
        k = 0;
        while (!fetch_ready && k < 4) begin
            @(negedge clk);
            k++;
        end
        if (!fetch_ready) begin
            errors++;
            $display("fetch_ready_o did not go high after reset");
        end
        @(posedge clk);
        #1;

        k = 0;
        while (k < N_DIR) begin
            i0 = row_instr(tab[k]);
            e0 = tab[k].exp;
            if (i0.rd != 0) golden[i0.rd] = e0;
            i1 = '0;
            e1 = '0;
            if (tab[k].solo) begin
                v = 2'b01;
                k += 1;
            end else begin
                i1 = row_instr(tab[k + 1]);
                e1 = tab[k + 1].exp;
                if (i1.rd != 0) golden[i1.rd] = e1;
                v = 2'b11;
                k += 2;
            end
            send_pair(v, i0, i1, e0, e1);
        end

        dir_stalls = stalls;
        repeat (N_RAND_PAIRS) begin
            v = ($urandom_range(0, 7) == 0) ? 2'b01 : 2'b11;
            i0 = random_instr();
            e0 = predict(i0);
            i1 = '0;
            e1 = '0;
            if (v[1]) begin
                i1 = random_instr();
                if (i0.rd != 0 && $urandom_range(0, 1) == 1) i1.rs1 = i0.rd;  // Force a split
                e1 = predict(i1);
            end
            send_pair(v, i0, i1, e0, e1);
        end
        if (stalls == dir_stalls) begin
            errors++;
            $display("The random burst never saw fetch_ready_o low, the buffer did not fill");
        end

        while (exp_q.size() != 0) @(negedge clk);
        repeat (4) @(negedge clk);
        errors += core_top_inst.core_checker_inst.assert_fails;
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+.
core_pkg.sv
instr_buffer.sv
regfile.sv
dispatch.sv
alu_lane.sv
core_top.sv
core_checker.sv
core_clock_gen.sv
core_tb.sv

// ==== Bender.yml ====
package:
  name: core

sources:
  - include_dirs:
      - .
    files:
      - core_pkg.sv
      - instr_buffer.sv
      - regfile.sv
      - dispatch.sv
      - alu_lane.sv
      - core_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - core_checker.sv
      - core_clock_gen.sv
      - core_tb.sv
